// File: Makefile
TOP = tb_alu_top

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -Mdir obj_dir -o sim

run: build
	./obj_dir/sim 2>&1 | tee sim.log
	grep -q "All checks passed" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module alu_top -f verilog.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: hdl/alu_core.sv
// ======================================================================
// Combinational ALU core.
// Selects the operation, turns a subtract into an add of the inverted
// operand with carry in set, and forms the carry, overflow, zero and
// negative flags. Logic operations go around the adder.
// ======================================================================
`default_nettype none

module alu_core import alu_pkg::*; (
  input  wire alu_req_t req,
  output alu_rsp_t      rsp
);

  // Operand and carry as presented to the adder.
  alu_word_t adder_b;
  logic      adder_cin;

  // Adder outputs.
  alu_word_t adder_sum;
  logic      adder_cout;

  // High for add and subtract.
  logic is_arith;

  // Selected result word.
  alu_word_t result;

  // Signed overflow of the adder, valid for arithmetic only.
  logic adder_ovf;

  // A subtract is a plus the two's complement of b. The inversion is
  // done here, and the +1 comes in as the adder carry.
  assign adder_b   = (req.op == op_sub) ? ~req.b : req.b;
  assign adder_cin = (req.op == op_sub);

  cla_adder16 i_cla_adder16 (
    .a    (req.a),
    .b    (adder_b),
    .cin  (adder_cin),
    .sum  (adder_sum),
    .cout (adder_cout)
  );

  always_comb begin
    is_arith = 1'b0;
    result   = '0;
    case (req.op)
      op_add, op_sub: begin
        is_arith = 1'b1;
        result   = adder_sum;
      end
      op_and:  result = req.a & req.b;
      op_or:   result = req.a | req.b;
      op_xor:  result = req.a ^ req.b;
      // Unused encodings give a zero result with no carry.
      default: result = '0;
    endcase
  end

  // Overflow happens when both adder inputs have the same sign and
  // the sum comes out with the other sign.
  assign adder_ovf = (req.a[alu_width-1] == adder_b[alu_width-1]) &&
                     (adder_sum[alu_width-1] != req.a[alu_width-1]);

  assign rsp.result         = result;
  assign rsp.flags.carry    = is_arith & adder_cout;
  assign rsp.flags.overflow = is_arith & adder_ovf;

  // Zero and negative look at the result only.
  assign rsp.flags.zero     = (result == '0);
  assign rsp.flags.negative = result[alu_width-1];

endmodule

`default_nettype wire

// File: hdl/alu_pkg.sv
// ======================================================================
// Shared definitions for the registered 16-bit ALU.
// Holds the data widths, the operation encoding and the packed request,
// flag and response records that travel between the ALU blocks.
// Modules take these with a wildcard import in their header.
// ======================================================================
`default_nettype none

package alu_pkg;

  // Data width of the ALU and of the adder behind it.
  localparam int alu_width = 16;

  // Each lookahead group covers this many bits.
  localparam int cla_group_width = 4;

  // Number of groups under the second-level lookahead unit.
  localparam int cla_num_groups = alu_width / cla_group_width;

  // One data word, as seen on the operands and the result.
  typedef logic [alu_width-1:0] alu_word_t;

  // Operand or sum slice handled by a single lookahead group.
  typedef logic [cla_group_width-1:0] cla_nibble_t;

  // Operation select. The arithmetic ops come first.
  typedef enum logic [2:0] {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_and = 3'd2,
    op_or  = 3'd3,
    op_xor = 3'd4
  } alu_op_t;

  // A request carries the operation and both operands.
  typedef struct packed {
    alu_op_t   op;
    alu_word_t a;
    alu_word_t b;
  } alu_req_t;

  // Condition flags. Carry set on a subtract means no borrow occurred.
  typedef struct packed {
    logic carry;
    logic overflow;
    logic zero;
    logic negative;
  } alu_flags_t;

  // A response is the result word with its flags.
  typedef struct packed {
    alu_word_t  result;
    alu_flags_t flags;
  } alu_rsp_t;

endpackage

`default_nettype wire

// File: hdl/alu_top.sv
// ======================================================================
// Registered 16-bit ALU.
// Drive in_valid high for one cycle with a request on req. The matching
// response appears on rsp, with out_valid high for one cycle, two
// cycles later. A new request may enter every cycle, and responses
// leave in order. There is no back-pressure.
// ======================================================================
`default_nettype none

module alu_top import alu_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst,
  input  wire logic     in_valid,
  input  wire alu_req_t req,
  output logic          out_valid,
  output alu_rsp_t      rsp
);

  // Request stage.
  alu_req_t req_q;
  logic     req_valid_q;

  // Core output, read by the response stage.
  alu_rsp_t core_rsp;

  // The request payload only loads on a valid strobe.
  always_ff @(posedge clk) begin
    if (in_valid) begin
      req_q <= req;
    end
  end

  alu_core i_alu_core (
    .req (req_q),
    .rsp (core_rsp)
  );

  // Valid pipeline and response register.
  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid_q <= 1'b0;
      out_valid   <= 1'b0;
      rsp         <= '0;
    end else begin
      req_valid_q <= in_valid;
      out_valid   <= req_valid_q;
      if (req_valid_q) begin
        rsp <= core_rsp;
      end
    end
  end

  // Every response strobe traces back to a request two cycles earlier.
  a_latency: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> $past(in_valid, 2));

  // The zero flag must match the registered result word.
  a_zero_flag: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> (rsp.flags.zero == (rsp.result == '0)));

  // Reset clears both stages of the strobe pipeline.
  a_reset_quiet: assert property (@(posedge clk)
    rst |=> (!out_valid && !req_valid_q));

endmodule

`default_nettype wire

// File: hdl/cla_adder16.sv
// ======================================================================
// Second-level 16-bit carry-lookahead adder.
// Four 4-bit groups report generate and propagate to one top-level
// lookahead unit, which sends each group its carry in. The carry out is
// formed from the 16-bit generate and propagate and the carry in.
// The caller, normally the ALU core, supplies the carry in.
// ======================================================================
`default_nettype none

module cla_adder16 import alu_pkg::*; (
  input  wire alu_word_t a,
  input  wire alu_word_t b,
  input  wire logic      cin,
  output alu_word_t      sum,
  output logic           cout
);

  // Group generate and propagate, one pair per 4-bit group.
  logic [cla_num_groups-1:0] grp_g;
  logic [cla_num_groups-1:0] grp_p;

  // Carry into each group. Group 0 takes the adder carry in.
  logic [cla_num_groups-1:0] grp_carry;

  // Carries from the top lookahead unit into groups 1 to 3.
  logic [cla_num_groups-2:0] top_carry;

  // Generate and propagate across the full word.
  logic word_g;
  logic word_p;

  // One 4-bit group per slice of the word.
  for (genvar gi = 0; gi < cla_num_groups; gi++) begin : g_group
    cla_group4 i_cla_group4 (
      .a       (a[gi*cla_group_width +: cla_group_width]),
      .b       (b[gi*cla_group_width +: cla_group_width]),
      .cin     (grp_carry[gi]),
      .sum     (sum[gi*cla_group_width +: cla_group_width]),
      .group_g (grp_g[gi]),
      .group_p (grp_p[gi])
    );
  end

  // The same lookahead unit, now working on whole groups.
  cla_lookahead i_cla_lookahead_top (
    .g       (grp_g),
    .p       (grp_p),
    .cin     (cin),
    .carry   (top_carry),
    .group_g (word_g),
    .group_p (word_p)
  );

  assign grp_carry = {top_carry, cin};

  // Only the outermost level needs a real carry out.
  assign cout = word_g | (word_p & cin);

endmodule

`default_nettype wire

// File: hdl/cla_group4.sv
// ======================================================================
// First-level 4-bit carry-lookahead adder.
// Builds per-bit generate, propagate and sum terms and takes its inner
// carries from one lookahead unit instead of rippling them. The group
// generate and propagate feed the second-level lookahead unit above.
// ======================================================================
`default_nettype none

module cla_group4 import alu_pkg::*; (
  input  wire cla_nibble_t a,
  input  wire cla_nibble_t b,
  input  wire logic        cin,
  output cla_nibble_t      sum,
  output logic             group_g,
  output logic             group_p
);

  // Per-bit generate and propagate.
  cla_nibble_t bit_g;
  cla_nibble_t bit_p;

  // Carries out of the lookahead unit, positions 1 to 3.
  logic [cla_group_width-2:0] inner_carry;

  // Carry into each bit. Bit 0 takes the group carry in directly.
  cla_nibble_t bit_carry;

  // The bit cell is a full adder that reports generate and propagate
  // instead of a carry out.
  // Propagate uses OR rather than XOR. That is still correct for the
  // carries, because when both bits are set the generate term already
  // covers the carry.
  assign bit_g = a & b;
  assign bit_p = a | b;

  cla_lookahead i_cla_lookahead (
    .g       (bit_g),
    .p       (bit_p),
    .cin     (cin),
    .carry   (inner_carry),
    .group_g (group_g),
    .group_p (group_p)
  );

  assign bit_carry = {inner_carry, cin};

  // Sum bits use the XOR of the operands, never the OR propagate.
  assign sum = a ^ b ^ bit_carry;

endmodule

`default_nettype wire

// File: hdl/cla_lookahead.sv
// ======================================================================
// Four-wide carry-lookahead unit.
// Takes four generate/propagate pairs and a carry in, and returns the
// carries into positions 1 to 3 together with the group generate and
// group propagate. Used both inside a 4-bit group and at the top level.
// ======================================================================
`default_nettype none

module cla_lookahead import alu_pkg::*; (
  input  wire logic [cla_group_width-1:0] g,
  input  wire logic [cla_group_width-1:0] p,
  input  wire logic                       cin,
  output logic      [cla_group_width-2:0] carry,
  output logic                            group_g,
  output logic                            group_p
);

  // Every carry is written out in flat sum-of-products form.
  // No carry depends on another carry, so all of them settle
  // after the same two gate levels.

  // Carry into position 1.
  assign carry[0] = g[0] | (p[0] & cin);

  // Carry into position 2.
  assign carry[1] = g[1] |
                    (p[1] & g[0]) |
                    (p[1] & p[0] & cin);

  // Carry into position 3.
  assign carry[2] = g[2] |
                    (p[2] & g[1]) |
                    (p[2] & p[1] & g[0]) |
                    (p[2] & p[1] & p[0] & cin);

  // The group generates a carry when some position generates one
  // and every position above it passes that carry on.
  assign group_g = g[3] |
                   (p[3] & g[2]) |
                   (p[3] & p[2] & g[1]) |
                   (p[3] & p[2] & p[1] & g[0]);

  // The group passes an incoming carry only if every position does.
  assign group_p = &p;

endmodule

`default_nettype wire

// File: verif/alu_checker.sv
// ======================================================================
// Response checker for the registered ALU.
// Expected responses are pushed with exp_valid in the cycle that their
// request is sampled. Each out_valid pops one entry, and the result,
// every flag and the two-cycle latency are compared against it.
// Call finish_check at the end of the run to get the error total.
// ======================================================================
`default_nettype none

module alu_checker import alu_pkg::*; (
  input wire logic     clk,
  input wire logic     rst,
  input wire logic     out_valid,
  input wire alu_rsp_t rsp,
  input wire logic     exp_valid,
  input wire alu_rsp_t exp_rsp
);

  // Responses still owed by the DUT, oldest first, with the cycle of
  // the request that each one belongs to.
  alu_rsp_t exp_q[$];
  int       issue_q[$];

  int       cycle = 0;
  int       value_errors = 0;
  int       protocol_errors = 0;
  int       checked = 0;
  alu_rsp_t expected;
  int       issued;

  // Reports one field that differs from its expected value.
  task automatic compare_field(input string name, input logic [15:0] got,
                               input logic [15:0] want);
    if (got !== want) begin
      $display("** Error: %s got 0x%h expected 0x%h at cycle %0d", name, got, want, cycle);
      value_errors++;
    end
  endtask

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (rst) begin
      // The output strobe must stay quiet for the whole reset.
      if (out_valid === 1'b1) begin
        $display("out_valid went high during reset at cycle %0d", cycle);
        protocol_errors++;
      end
    end else if (out_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("out_valid seen with no request outstanding at cycle %0d", cycle);
        protocol_errors++;
      end else begin
        expected = exp_q.pop_front();
        issued   = issue_q.pop_front();
        checked++;
        if (cycle != issued + 2) begin
          $display("Response at cycle %0d belongs to a request from cycle %0d, latency wrong",
                   cycle, issued);
          protocol_errors++;
        end
        compare_field("rsp.result", rsp.result, expected.result);
        compare_field("rsp.flags.carry", 16'(rsp.flags.carry), 16'(expected.flags.carry));
        compare_field("rsp.flags.overflow", 16'(rsp.flags.overflow),
                      16'(expected.flags.overflow));
        compare_field("rsp.flags.zero", 16'(rsp.flags.zero), 16'(expected.flags.zero));
        compare_field("rsp.flags.negative", 16'(rsp.flags.negative),
                      16'(expected.flags.negative));
      end
    end
    // A push comes after the pop, so the queue holds only requests
    // from this edge and earlier.
    if (exp_valid) begin
      exp_q.push_back(exp_rsp);
      issue_q.push_back(cycle);
    end
  end

  // Flags responses that never came, then prints the closing line.
  task automatic finish_check(output int total);
    if (exp_q.size() != 0) begin
      $display("%0d expected responses never arrived", exp_q.size());
      protocol_errors++;
    end
    total = value_errors + protocol_errors;
    $display("Checker: %0d responses checked, %0d value errors, %0d protocol errors",
             checked, value_errors, protocol_errors);
  endtask

endmodule

`default_nettype wire

// File: verif/tb_alu_top.sv
// ======================================================================
// Testbench for the registered ALU.
// Builds a table of directed and random requests with their expected
// responses, drives one row per cycle on the falling clock edge, and
// hands each expected response to the checker. A watchdog bounds the
// run from the table length.
// ======================================================================
`default_nettype none

module tb_alu_top import alu_pkg::*; ();

  typedef struct packed {
    logic     valid;
    alu_req_t req;
    alu_rsp_t exp;
  } row_t;

  localparam int num_directed = 15;
  localparam int num_random = 24;
  localparam int num_rows = num_directed + num_random;
  localparam int clk_period = 100;

  logic     clk = 1'b0;
  logic     rst;
  logic     in_valid;
  alu_req_t req;
  logic     out_valid;
  alu_rsp_t rsp;
  logic     exp_valid;
  alu_rsp_t exp_rsp;
  row_t     rows [num_rows];
  int       seed_val;
  int       total_errors;

  always #(clk_period / 2) clk = ~clk;

  alu_top i_alu_top (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .req       (req),
    .out_valid (out_valid),
    .rsp       (rsp)
  );

  alu_checker i_alu_checker (
    .clk       (clk),
    .rst       (rst),
    .out_valid (out_valid),
    .rsp       (rsp),
    .exp_valid (exp_valid),
    .exp_rsp   (exp_rsp)
  );

  // Packs one table row. Flags are given as {carry, overflow, zero, negative}.
  function automatic row_t make_row(input logic valid, input alu_op_t op,
                                    input alu_word_t a, input alu_word_t b,
                                    input alu_word_t result, input logic [3:0] flags);
    row_t r;
    r.valid      = valid;
    r.req        = '{op: op, a: a, b: b};
    r.exp.result = result;
    r.exp.flags  = flags;
    return r;
  endfunction

  // Expected response from plain integer arithmetic. Overflow is a
  // signed result outside the 16-bit range, and a subtract carries
  // when no borrow is needed.
  function automatic alu_rsp_t expect_rsp(input alu_req_t r);
    alu_rsp_t   e;
    logic [16:0] wide;
    int         sa;
    int         sb;
    int         sres;
    sa = int'(signed'(r.a));
    sb = int'(signed'(r.b));
    e = '0;
    case (r.op)
      op_add: begin
        wide = {1'b0, r.a} + {1'b0, r.b};
        sres = sa + sb;
        e.result = wide[15:0];
        e.flags.carry = wide[16];
        e.flags.overflow = (sres > 32767) || (sres < -32768);
      end
      op_sub: begin
        sres = sa - sb;
        e.result = r.a - r.b;
        e.flags.carry = (r.a >= r.b);
        e.flags.overflow = (sres > 32767) || (sres < -32768);
      end
      op_and: e.result = r.a & r.b;
      op_or: e.result = r.a | r.b;
      default: e.result = r.a ^ r.b;
    endcase
    e.flags.zero = (e.result == 16'h0000);
    e.flags.negative = e.result[15];
    return e;
  endfunction

  // Ends a run that stalls long past the length of the table.
  initial begin
    #((num_rows + 10) * clk_period);
    $display("Timeout: the run did not finish in %0d time units",
             (num_rows + 10) * clk_period);
    $display("Checks failed");
    $finish;
  end

  initial begin
    seed_val = $urandom(32'hda55);
    rst = 1'b1;
    in_valid = 1'b0;
    req = '0;
    exp_valid = 1'b0;
    exp_rsp = '0;

    // Carries across every group, then signed overflow cases.
    rows[0]  = make_row(1'b1, op_add, 16'hffff, 16'h0001, 16'h0000, 4'b1010);
    rows[1]  = make_row(1'b1, op_add, 16'h00ff, 16'h0f01, 16'h1000, 4'b0000);
    rows[2]  = make_row(1'b1, op_add, 16'h7fff, 16'h0001, 16'h8000, 4'b0101);
    rows[3]  = make_row(1'b1, op_add, 16'h1234, 16'h4321, 16'h5555, 4'b0000);
    rows[4]  = make_row(1'b1, op_sub, 16'h5555, 16'h5555, 16'h0000, 4'b1010);
    rows[5]  = make_row(1'b1, op_sub, 16'h0001, 16'h0002, 16'hffff, 4'b0001);
    rows[6]  = make_row(1'b1, op_sub, 16'h8000, 16'h0001, 16'h7fff, 4'b1100);
    rows[7]  = make_row(1'b1, op_add, 16'h8000, 16'h8000, 16'h0000, 4'b1110);
    rows[8]  = make_row(1'b1, op_and, 16'hf0f0, 16'h3c3c, 16'h3030, 4'b0000);
    rows[9]  = make_row(1'b1, op_or,  16'hf0f0, 16'h0f0f, 16'hffff, 4'b0001);
    rows[10] = make_row(1'b1, op_xor, 16'haaaa, 16'haaaa, 16'h0000, 4'b0010);
    // Two idle cycles between bursts.
    rows[11] = make_row(1'b0, op_add, 16'h0000, 16'h0000, 16'h0000, 4'b0000);
    rows[12] = make_row(1'b0, op_add, 16'h0000, 16'h0000, 16'h0000, 4'b0000);
    rows[13] = make_row(1'b1, op_sub, 16'h0000, 16'h0001, 16'hffff, 4'b0001);
    rows[14] = make_row(1'b1, op_add, 16'hffff, 16'hffff, 16'hfffe, 4'b1001);

    // Random rows, about one in four left idle.
    for (int i = num_directed; i < num_rows; i++) begin
      rows[i].valid = ($urandom_range(3, 0) != 0);
      rows[i].req.op = alu_op_t'(3'($urandom_range(4, 0)));
      rows[i].req.a = 16'($urandom);
      rows[i].req.b = 16'($urandom);
      rows[i].exp = expect_rsp(rows[i].req);
    end

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    for (int i = 0; i < num_rows; i++) begin
      in_valid = rows[i].valid;
      req = rows[i].req;
      exp_valid = rows[i].valid;
      exp_rsp = rows[i].exp;
      @(negedge clk);
    end
    in_valid = 1'b0;
    exp_valid = 1'b0;

    // The latency is fixed at two cycles, so this drains the pipeline.
    repeat (4) @(negedge clk);
    i_alu_checker.finish_check(total_errors);
    if (total_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
hdl/alu_pkg.sv
hdl/cla_lookahead.sv
hdl/cla_group4.sv
hdl/cla_adder16.sv
hdl/alu_core.sv
hdl/alu_top.sv
verif/alu_checker.sv
verif/tb_alu_top.sv
